//--- dv/cache_golden.txt
// Columns: opcode, word address, write data, expected data, all hex.
// Opcodes: 1 read, 9 read that must hit, 2 write, 3 flush, 4 w_flush, 5 mem-check, 0 end.
00000001 00000005 00000000 5a5a0005
00000009 00000006 00000000 5a5a0006
00000009 00000005 00000000 5a5a0005
00000002 00000009 dead0009 00000000
00000009 00000009 00000000 dead0009
00000009 0000000a 00000000 5a5a000a
00000002 00000006 11110006 00000000
00000009 00000006 00000000 11110006
00000001 00000025 00000000 5a5a0025
00000002 00000047 22220047 00000000
00000001 00000006 00000000 11110006
00000001 00000024 00000000 5a5a0024
00000001 00000047 00000000 22220047
00000009 00000047 00000000 22220047
00000002 00000044 33330044 00000000
00000004 00000000 00000000 00000000
00000005 00000044 00000000 33330044
00000005 00000009 00000000 dead0009
00000009 00000044 00000000 33330044
00000009 00000009 00000000 dead0009
00000002 00000061 44440061 00000000
00000002 0000000b 5555000b 00000000
00000003 00000000 00000000 00000000
00000005 00000061 00000000 44440061
00000005 0000000b 00000000 5555000b
00000005 00000044 00000000 33330044
00000005 00000062 00000000 5a5a0062
00000001 00000061 00000000 44440061
00000001 0000000b 00000000 5555000b
00000009 00000062 00000000 5a5a0062
00000000 00000000 00000000 00000000

//--- filelist.f
+incdir+include
rtl/cache_pkg.sv
rtl/raw_block_ram.sv
rtl/cache_tag_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
dv/ext_mem_model.sv
dv/cache_tb.sv

//--- Makefile
# Verilator build and run of the cache testbench.
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@echo "No failure found in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/cache_tb.sv
// Data cache testbench
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;

    // Golden table capacity in lines.
    localparam int MAX_LINES = 64;
    // Watchdog budget per golden line.
    localparam int CYCLES_PER_LINE = 200;
    // Reset plus tag clear allowance.
    localparam int INIT_CYCLES = 64;
    localparam int RESET_CYCLES = 8;
    // Hit read latency in cycles.
    localparam int HIT_LATENCY = 2;

    // Opcodes of the golden file.
    localparam logic [31:0] OP_END      = 32'h0;
    localparam logic [31:0] OP_READ     = 32'h1;
    localparam logic [31:0] OP_WRITE    = 32'h2;
    localparam logic [31:0] OP_FLUSH    = 32'h3;
    localparam logic [31:0] OP_WFLUSH   = 32'h4;
    localparam logic [31:0] OP_MEMCHECK = 32'h5;
    localparam logic [31:0] OP_READ_HIT = 32'h9;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                w_flush;
    cache_pkg::mem_req_t bus_req;
    cache_pkg::mem_rsp_t bus_rsp;
    cache_pkg::mem_req_t xm_req;
    cache_pkg::mem_rsp_t xm_rsp;

    // Op, address, write data and expected data per golden line.
    logic [31:0] golden [MAX_LINES*4];
    int          n_lines;
    int          errors;
    logic        loaded;

    cache_top i_cache_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .w_flush(w_flush),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp),
        .xm_req (xm_req),
        .xm_rsp (xm_rsp)
    );

    ext_mem_model #(
        .delay(3)
    ) i_ext_mem_model (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (xm_req),
        .rsp  (xm_rsp)
    );

    // 4 ns clock.
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("MISMATCH %s: got 0x%08h expected 0x%08h at %0t",
                     name, got, expected, $time);
        end
    endtask

    // Hold the request until the cache takes it.
    // Returns one ns after the accepting edge.
    task automatic issue_request(input logic we, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        logic accepted;
        bus_req.valid     = 1'b1;
        bus_req.we        = we;
        bus_req.addr.word = addr[`CACHE_WORD_BITS-1:0];
        bus_req.wdata     = wdata;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = bus_rsp.ready;
            @(posedge clk);
            #1;
        end
        bus_req.valid = 1'b0;
    endtask

    // Read, check the data, and on request the hit latency.
    task automatic read_and_check(input logic [31:0] addr, input logic [31:0] expected,
                                  input logic check_hit);
        int latency;
        issue_request(1'b0, addr, 32'h0);
        latency = 1;
        @(negedge clk);
        while (!bus_rsp.rvalid) begin
            @(negedge clk);
            latency++;
        end
        compare("bus_rsp.rdata", bus_rsp.rdata, expected);
        if (check_hit) begin
            compare("read_latency", 32'(latency), 32'(HIT_LATENCY));
        end
        @(posedge clk);
        #1;
    endtask

    // Write, then wait for ready to come back.
    task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata);
        issue_request(1'b1, addr, wdata);
        @(negedge clk);
        while (!bus_rsp.ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // One-cycle flush pulse, then wait for the sweep to end.
    task automatic sweep_cache(input logic clean_only);
        if (clean_only) begin
            w_flush = 1'b1;
        end else begin
            flush = 1'b1;
        end
        @(posedge clk);
        #1;
        flush   = 1'b0;
        w_flush = 1'b0;
        @(negedge clk);
        while (!bus_rsp.ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_memory(input logic [31:0] addr, input logic [31:0] expected);
        compare($sformatf("ext_mem[0x%04h]", addr[`CACHE_WORD_BITS-1:0]),
                i_ext_mem_model.mem[addr[`CACHE_WORD_BITS-1:0]], expected);
    endtask

    task automatic run_line(input int idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        op       = golden[4*idx];
        addr     = golden[4*idx+1];
        wdata    = golden[4*idx+2];
        expected = golden[4*idx+3];
        case (op)
            OP_READ:     read_and_check(addr, expected, 1'b0);
            OP_READ_HIT: read_and_check(addr, expected, 1'b1);
            OP_WRITE:    write_word(addr, wdata);
            OP_FLUSH:    sweep_cache(1'b0);
            OP_WFLUSH:   sweep_cache(1'b1);
            OP_MEMCHECK: check_memory(addr, expected);
            default: begin
                errors++;
                $display("Golden line %0d has an unknown opcode 0x%08h", idx, op);
            end
        endcase
    endtask

    // Main sequence.
    initial begin
        int wait_cycles;
        bus_req = '0;
        flush   = 1'b0;
        w_flush = 1'b0;
        rst_n   = 1'b0;
        errors  = 0;
        n_lines = 0;
        loaded  = 1'b0;
        for (int i = 0; i < MAX_LINES * 4; i++) begin
            golden[i] = '0;
        end
        $readmemh("dv/cache_golden.txt", golden);
        // List ends at the first zero opcode.
        while (n_lines < MAX_LINES && golden[4*n_lines] != OP_END) begin
            n_lines++;
        end
        loaded = 1'b1;
        if (n_lines == 0) begin
            errors++;
            $display("No operations were loaded from the golden file");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Quiet buses out of reset.
        compare("bus_rsp.rvalid", 32'(bus_rsp.rvalid), 32'h0);
        compare("xm_req.valid", 32'(xm_req.valid), 32'h0);
        // Ready comes up once the tag clear walk is done.
        wait_cycles = 0;
        while (!bus_rsp.ready && wait_cycles < INIT_CYCLES) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        compare("bus_rsp.ready", 32'(bus_rsp.ready), 32'h1);
        for (int i = 0; i < n_lines; i++) begin
            run_line(i);
        end
        $display("Run finished: %0d golden lines, %0d errors", n_lines, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized from the golden length.
    initial begin
        int budget;
        wait (loaded);
        budget = n_lines * CYCLES_PER_LINE + 2 * INIT_CYCLES;
        repeat (budget) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", budget);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- dv/ext_mem_model.sv
// External memory model
`timescale 1ns/1ps
`include "cache_config.svh"

module ext_mem_model #(
    // Cycles from read acceptance to rvalid.
    parameter int delay = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::mem_req_t req,
    output cache_pkg::mem_rsp_t rsp
);

    localparam int DEPTH = 2 ** `CACHE_WORD_BITS;

    // One word per word address.
    logic [31:0]                 mem [DEPTH];
    logic                        pend;
    int                          wait_cnt;
    logic [`CACHE_WORD_BITS-1:0] raddr;
    logic                        rvalid;
    logic [31:0]                 rdata;

    // Start contents follow the address.
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = 32'(a) ^ 32'h5a5a_0000;
        end
    end

    // Busy while a read is outstanding.
    assign rsp.ready  = !pend;
    assign rsp.rvalid = rvalid;
    assign rsp.rdata  = rdata;

    always @(posedge clk) begin
        if (!rst_n) begin
            pend     <= 1'b0;
            rvalid   <= 1'b0;
            wait_cnt <= 0;
        end else begin
            rvalid <= 1'b0;
            if (req.valid && rsp.ready) begin
                if (req.we) begin
                    // Writes land at acceptance.
                    mem[req.addr.word] <= req.wdata;
                end else begin
                    pend     <= 1'b1;
                    raddr    <= req.addr.word;
                    wait_cnt <= delay - 1;
                end
            end else if (pend) begin
                if (wait_cnt <= 1) begin
                    // One-cycle data pulse.
                    rvalid <= 1'b1;
                    rdata  <= mem[raddr];
                    pend   <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

//--- rtl/cache_top.sv
// Write-back data cache
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                w_flush,
    input  cache_pkg::mem_req_t bus_req,
    output cache_pkg::mem_rsp_t bus_rsp,
    output cache_pkg::mem_req_t xm_req,
    input  cache_pkg::mem_rsp_t xm_rsp
);

    // Tag store wires.
    logic [`CACHE_IDX_BITS-1:0]              tag_index;
    logic                                    tag_we;
    cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] tag_wentry;
    logic [`CACHE_WAY_BITS-1:0]              tag_wnext;
    logic [`CACHE_TAG_BITS-1:0]              tag_rtag;
    logic                                    tag_hit;
    logic [`CACHE_WAY_BITS-1:0]              tag_hit_way;
    logic [`CACHE_WAY_BITS-1:0]              tag_victim_way;
    cache_pkg::tag_entry_t                   tag_victim_entry;
    logic [`CACHE_WAY_BITS-1:0]              tag_next_way;
    cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] tag_rentry;

    // Data RAM wires.
    logic [`CACHE_DATA_ABITS-1:0] data_addr;
    logic                         data_we;
    logic [31:0]                  data_wdata;
    logic [31:0]                  data_rdata;

    cache_tag_store i_tag_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .index       (tag_index),
        .we          (tag_we),
        .wentry      (tag_wentry),
        .wnext       (tag_wnext),
        .rtag        (tag_rtag),
        .hit         (tag_hit),
        .hit_way     (tag_hit_way),
        .victim_way  (tag_victim_way),
        .victim_entry(tag_victim_entry),
        .next_way    (tag_next_way),
        .rentry      (tag_rentry)
    );

    // One word per entry.
    raw_block_ram #(
        .abits(`CACHE_DATA_ABITS),
        .dbits(32)
    ) i_data_ram (
        .clk  (clk),
        .we   (data_we),
        .addr (data_addr),
        .wdata(data_wdata),
        .rdata(data_rdata)
    );

    cache_ctrl i_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .w_flush         (w_flush),
        .bus_req         (bus_req),
        .bus_rsp         (bus_rsp),
        .xm_req          (xm_req),
        .xm_rsp          (xm_rsp),
        .tag_index       (tag_index),
        .tag_we          (tag_we),
        .tag_wentry      (tag_wentry),
        .tag_wnext       (tag_wnext),
        .tag_rtag        (tag_rtag),
        .tag_hit         (tag_hit),
        .tag_hit_way     (tag_hit_way),
        .tag_victim_way  (tag_victim_way),
        .tag_victim_entry(tag_victim_entry),
        .tag_next_way    (tag_next_way),
        .tag_rentry      (tag_rentry),
        .data_addr       (data_addr),
        .data_we         (data_we),
        .data_wdata      (data_wdata),
        .data_rdata      (data_rdata)
    );

endmodule

//--- rtl/cache_ctrl.sv
// Cache control FSM
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush,
    input  logic                                    w_flush,
    input  cache_pkg::mem_req_t                     bus_req,
    output cache_pkg::mem_rsp_t                     bus_rsp,
    output cache_pkg::mem_req_t                     xm_req,
    input  cache_pkg::mem_rsp_t                     xm_rsp,
    // Tag store side.
    output logic [`CACHE_IDX_BITS-1:0]              tag_index,
    output logic                                    tag_we,
    output cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] tag_wentry,
    output logic [`CACHE_WAY_BITS-1:0]              tag_wnext,
    output logic [`CACHE_TAG_BITS-1:0]              tag_rtag,
    input  logic                                    tag_hit,
    input  logic [`CACHE_WAY_BITS-1:0]              tag_hit_way,
    input  logic [`CACHE_WAY_BITS-1:0]              tag_victim_way,
    input  cache_pkg::tag_entry_t                   tag_victim_entry,
    input  logic [`CACHE_WAY_BITS-1:0]              tag_next_way,
    input  cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] tag_rentry,
    // Data RAM side.
    output logic [`CACHE_DATA_ABITS-1:0]            data_addr,
    output logic                                    data_we,
    output logic [31:0]                             data_wdata,
    input  logic [31:0]                             data_rdata
);

    localparam int WB = `CACHE_WAY_BITS;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_LOOKUP,
        ST_WB,
        ST_FILL,
        ST_RESP,
        ST_SWEEP
    } state_t;

    state_t                     state;
    cache_pkg::mem_req_t        req_q;
    logic [`CACHE_IDX_BITS-1:0] set_q;
    logic [WB-1:0]              way_q;
    logic [`CACHE_TAG_BITS-1:0] vtag_q;
    logic [`CACHE_OFS_BITS-1:0] cnt;
    logic                       data_ok;
    logic                       xm_wait;
    logic                       from_fill;
    logic [31:0]                fill_word;
    logic [WB-1:0]              s_way;
    logic                       sw_ok;
    logic                       wb_done;
    logic                       sweeping;
    logic                       clean_q;
    logic                       flush_pend;
    logic                       wflush_pend;
    logic                       acc;
    logic                       xm_acc;
    logic                       fill_last;
    logic [31:0]                fill_data;
    cache_pkg::tag_entry_t      sweep_ent;
    logic                       sweep_wb;

    assign acc       = bus_req.valid && bus_rsp.ready;
    assign xm_acc    = xm_req.valid && xm_rsp.ready;
    assign fill_last = (cnt == '1);
    // Write miss data is merged into the incoming line.
    assign fill_data = (req_q.we && cnt == req_q.addr.f.offset) ? req_q.wdata : xm_rsp.rdata;
    assign sweep_ent = tag_rentry[s_way];
    // Sweep entry needs its line written back first.
    assign sweep_wb  = sw_ok && sweep_ent.valid && sweep_ent.dirty && !wb_done;

    // CPU response.
    always_comb begin
        bus_rsp.ready  = (state == ST_IDLE) && !(flush || w_flush || flush_pend || wflush_pend);
        bus_rsp.rvalid = (state == ST_RESP);
        bus_rsp.rdata  = from_fill ? fill_word : data_rdata;
    end

    // External request.
    // Write-back streams the victim line, fill reads the new one.
    always_comb begin
        xm_req.valid           = 1'b0;
        xm_req.we              = 1'b0;
        xm_req.wdata           = data_rdata;
        xm_req.addr.f.tag      = req_q.addr.f.tag;
        xm_req.addr.f.index    = set_q;
        xm_req.addr.f.offset   = cnt;
        if (state == ST_WB) begin
            xm_req.valid      = data_ok;
            xm_req.we         = 1'b1;
            xm_req.addr.f.tag = vtag_q;
        end else if (state == ST_FILL) begin
            xm_req.valid = !xm_wait;
        end
    end

    // Tag and data RAM control.
    always_comb begin
        tag_index  = (state == ST_IDLE) ? bus_req.addr.f.index : set_q;
        tag_rtag   = (state == ST_IDLE) ? bus_req.addr.f.tag : req_q.addr.f.tag;
        tag_we     = 1'b0;
        tag_wentry = tag_rentry;
        tag_wnext  = tag_next_way;
        data_we    = 1'b0;
        data_wdata = req_q.wdata;
        data_addr  = {set_q, way_q, cnt};
        case (state)
            ST_LOOKUP: begin
                // Hit way read, or written for a store.
                data_addr = {set_q, tag_hit_way, req_q.addr.f.offset};
                if (tag_hit && req_q.we) begin
                    data_we                       = 1'b1;
                    tag_we                        = 1'b1;
                    tag_wentry[tag_hit_way].dirty = 1'b1;
                end
            end
            ST_FILL: begin
                data_wdata = fill_data;
                if (xm_wait && xm_rsp.rvalid) begin
                    data_we = 1'b1;
                    // New tag goes in with the last word.
                    if (fill_last) begin
                        tag_we                   = 1'b1;
                        tag_wentry[way_q].valid  = 1'b1;
                        tag_wentry[way_q].dirty  = req_q.we;
                        tag_wentry[way_q].tag    = req_q.addr.f.tag;
                        tag_wnext                = way_q + 1'b1;
                    end
                end
            end
            ST_SWEEP: begin
                // Clean, and drop unless only cleaning.
                if (sw_ok && !sweep_wb) begin
                    tag_we                  = 1'b1;
                    tag_wentry[s_way].dirty = 1'b0;
                    if (!clean_q) begin
                        tag_wentry[s_way].valid = 1'b0;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_INIT;
            set_q       <= '0;
            way_q       <= '0;
            cnt         <= '0;
            data_ok     <= 1'b0;
            xm_wait     <= 1'b0;
            from_fill   <= 1'b0;
            s_way       <= '0;
            sw_ok       <= 1'b0;
            wb_done     <= 1'b0;
            sweeping    <= 1'b0;
            clean_q     <= 1'b0;
            flush_pend  <= 1'b0;
            wflush_pend <= 1'b0;
        end else begin
            case (state)
                ST_INIT: begin
                    // Same count as the tag store clear.
                    set_q <= set_q + 1'b1;
                    if (set_q == '1) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (flush_pend || wflush_pend) begin
                        state       <= ST_SWEEP;
                        sweeping    <= 1'b1;
                        clean_q     <= !flush_pend;
                        flush_pend  <= 1'b0;
                        wflush_pend <= 1'b0;
                        set_q       <= '0;
                        s_way       <= '0;
                        sw_ok       <= 1'b0;
                        wb_done     <= 1'b0;
                    end else if (acc) begin
                        req_q <= bus_req;
                        set_q <= bus_req.addr.f.index;
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (tag_hit) begin
                        from_fill <= 1'b0;
                        state     <= req_q.we ? ST_IDLE : ST_RESP;
                    end else begin
                        way_q   <= tag_victim_way;
                        vtag_q  <= tag_victim_entry.tag;
                        cnt     <= '0;
                        data_ok <= 1'b0;
                        xm_wait <= 1'b0;
                        if (tag_victim_entry.valid && tag_victim_entry.dirty) begin
                            state <= ST_WB;
                        end else begin
                            state <= ST_FILL;
                        end
                    end
                end
                ST_WB: begin
                    // One cycle of RAM latency per word.
                    if (xm_acc) begin
                        data_ok <= 1'b0;
                        cnt     <= cnt + 1'b1;
                        if (cnt == '1) begin
                            wb_done <= 1'b1;
                            state   <= sweeping ? ST_SWEEP : ST_FILL;
                        end
                    end else begin
                        data_ok <= 1'b1;
                    end
                end
                ST_FILL: begin
                    if (xm_acc) begin
                        xm_wait <= 1'b1;
                    end
                    if (xm_wait && xm_rsp.rvalid) begin
                        xm_wait <= 1'b0;
                        cnt     <= cnt + 1'b1;
                        // Keep the requested word for the response.
                        if (cnt == req_q.addr.f.offset) begin
                            fill_word <= fill_data;
                        end
                        if (fill_last) begin
                            from_fill <= 1'b1;
                            state     <= req_q.we ? ST_IDLE : ST_RESP;
                        end
                    end
                end
                ST_RESP: begin
                    state <= ST_IDLE;
                end
                ST_SWEEP: begin
                    if (!sw_ok) begin
                        // Tag word read in flight.
                        sw_ok <= 1'b1;
                    end else if (sweep_wb) begin
                        way_q   <= s_way;
                        vtag_q  <= sweep_ent.tag;
                        cnt     <= '0;
                        data_ok <= 1'b0;
                        state   <= ST_WB;
                    end else begin
                        sw_ok   <= 1'b0;
                        wb_done <= 1'b0;
                        s_way   <= s_way + 1'b1;
                        if (s_way == WB'(`CACHE_WAYS - 1)) begin
                            s_way <= '0;
                            set_q <= set_q + 1'b1;
                            if (set_q == '1) begin
                                sweeping <= 1'b0;
                                state    <= ST_IDLE;
                            end
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
            // Late pulses are kept for the next sweep.
            if (flush) begin
                flush_pend <= 1'b1;
            end
            if (w_flush) begin
                wflush_pend <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/cache_tag_store.sv
// Cache tag store
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tag_store (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`CACHE_IDX_BITS-1:0]              index,
    input  logic                                    we,
    input  cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] wentry,
    input  logic [`CACHE_WAY_BITS-1:0]              wnext,
    input  logic [`CACHE_TAG_BITS-1:0]              rtag,
    output logic                                    hit,
    output logic [`CACHE_WAY_BITS-1:0]              hit_way,
    output logic [`CACHE_WAY_BITS-1:0]              victim_way,
    output cache_pkg::tag_entry_t                   victim_entry,
    output logic [`CACHE_WAY_BITS-1:0]              next_way,
    output cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] rentry
);

    localparam int WB = `CACHE_WAY_BITS;
    // All ways plus the round-robin pointer.
    localparam int TW = $bits(cache_pkg::tag_entry_t) * `CACHE_WAYS + WB;

    logic                       clearing;
    logic [`CACHE_IDX_BITS-1:0] clr_idx;
    logic [`CACHE_TAG_BITS-1:0] rtag_q;
    logic                       ram_we;
    logic [`CACHE_IDX_BITS-1:0] ram_addr;
    logic [TW-1:0]              ram_wdata;
    logic [TW-1:0]              ram_rdata;

    // Walk every set once after reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clearing <= 1'b1;
            clr_idx  <= '0;
        end else if (clearing) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == '1) begin
                clearing <= 1'b0;
            end
        end
    end

    // Tag to compare, aligned with the RAM read.
    always_ff @(posedge clk) begin
        rtag_q <= rtag;
    end

    // Clear writes win over the controller.
    assign ram_we    = clearing || we;
    assign ram_addr  = clearing ? clr_idx : index;
    assign ram_wdata = clearing ? '0 : {wnext, wentry};

    raw_block_ram #(
        .abits(`CACHE_IDX_BITS),
        .dbits(TW)
    ) i_tag_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (ram_addr),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

    // Unpack the stored word.
    assign {next_way, rentry} = ram_rdata;

    // Lowest matching way hits.
    // Lowest invalid way is preferred as victim, else the oldest way.
    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        victim_way = next_way;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (rentry[w].valid && rentry[w].tag == rtag_q) begin
                hit     = 1'b1;
                hit_way = WB'(w);
            end
            if (!rentry[w].valid) begin
                victim_way = WB'(w);
            end
        end
    end

    assign victim_entry = rentry[victim_way];

endmodule

//--- rtl/raw_block_ram.sv
// Single-port block RAM
`timescale 1ns/1ps

module raw_block_ram #(
    // Address width, depth is 2**abits.
    parameter int abits = 8,
    // Word width.
    parameter int dbits = 32
) (
    input  logic             clk,
    input  logic             we,
    input  logic [abits-1:0] addr,
    input  logic [dbits-1:0] wdata,
    output logic [dbits-1:0] rdata
);

    // Storage array.
    logic [dbits-1:0] mem [2**abits];

    // Read-first port, old data comes out on a write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- rtl/cache_pkg.sv
// Cache bus and tag types
`include "cache_config.svh"

package cache_pkg;

    // Word address as seen by the cache lookup.
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0] tag;
        logic [`CACHE_IDX_BITS-1:0] index;
        logic [`CACHE_OFS_BITS-1:0] offset;
    } addr_fields_t;

    // Raw word address or its lookup fields.
    typedef union packed {
        logic [`CACHE_WORD_BITS-1:0] word;
        addr_fields_t                f;
    } cache_addr_u;

    // Request from a bus master.
    typedef struct packed {
        logic        valid;
        logic        we;
        cache_addr_u addr;
        logic [31:0] wdata;
    } mem_req_t;

    // Response from a bus slave.
    typedef struct packed {
        logic        ready;
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

    // One way of a tag word.
    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`CACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

endpackage

//--- include/cache_config.svh
// Cache geometry
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Byte address width.
`define CACHE_ALEN 16
// 32-bit words per line.
`define CACHE_LINE_WORDS 4
// Sets per way.
`define CACHE_LINES 8
// Ways per set.
`define CACHE_WAYS 2

// Word address width.
`define CACHE_WORD_BITS (`CACHE_ALEN - 2)
// Word offset within a line.
`define CACHE_OFS_BITS ($clog2(`CACHE_LINE_WORDS))
// Set index width.
`define CACHE_IDX_BITS ($clog2(`CACHE_LINES))
// Way select width.
`define CACHE_WAY_BITS ($clog2(`CACHE_WAYS))
// Tag width, what is left of the word address.
`define CACHE_TAG_BITS (`CACHE_WORD_BITS - `CACHE_IDX_BITS - `CACHE_OFS_BITS)
// Data RAM address is set, way and offset.
`define CACHE_DATA_ABITS (`CACHE_IDX_BITS + `CACHE_WAY_BITS + `CACHE_OFS_BITS)

`endif
